// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL, run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== direction_predictor.sv ====
// three history-indexed counter tables voting on conditional branch direction
`include "frontend_consts.svh"

module direction_predictor import frontend_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  addr_t    lookup_pc,
  input  hist_t    lookup_hist,
  output logic     pred_taken,
  input  resolve_t resolve
);

  localparam int n_tables = 3;
  localparam int n_entries = 1 << `PRED_IDX_W;
  localparam int hist_len [n_tables] = '{`HIST_A_W, `HIST_B_W, `HIST_W};

  // pc bits xor the newest len history bits, longer histories folded onto the index
  function automatic pred_idx_t table_index(addr_t pc, hist_t h, int len);
    pred_idx_t idx;
    idx = pc[`BLOCK_OFS_W +: `PRED_IDX_W];
    for (int i = 0; i < `HIST_W; i++) begin
      if (i < len) begin
        idx[i % `PRED_IDX_W] ^= h[i];
      end
    end
    return idx;
  endfunction

  function automatic ctr_t ctr_step(ctr_t c, logic up);
    if (up && c != 2'b11) begin
      return c + 2'd1;
    end
    if (!up && c != 2'b00) begin
      return c - 2'd1;
    end
    return c;
  endfunction

  ctr_t      tbl [n_tables][n_entries];
  pred_idx_t rd_idx [n_tables];
  pred_idx_t wr_idx [n_tables];
  logic [n_tables-1:0] msb;
  logic      train;

  always_comb begin
    for (int t = 0; t < n_tables; t++) begin
      rd_idx[t] = table_index(lookup_pc, lookup_hist, hist_len[t]);
      wr_idx[t] = table_index(resolve.src_pc, resolve.hist, hist_len[t]);
      msb[t] = tbl[t][rd_idx[t]][1];
    end
  end

  // majority of the three
  assign pred_taken = (msb[0] & msb[1]) | (msb[0] & msb[2]) | (msb[1] & msb[2]);

  assign train = resolve.valid && (resolve.kind == kind_cond);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < n_tables; t++) begin
        for (int i = 0; i < n_entries; i++) begin
          tbl[t][i] <= 2'b01; // weakly not taken
        end
      end
    end else if (train) begin
      for (int t = 0; t < n_tables; t++) begin
        tbl[t][wr_idx[t]] <= ctr_step(tbl[t][wr_idx[t]], resolve.taken);
      end
    end
  end

  // back end must return the fetch-time snapshot intact
  a_resolve_hist_known: assert property (
    @(posedge clk) disable iff (rst)
    resolve.valid |-> !$isunknown(resolve.hist)
  ) else $error("resolve history unknown");

endmodule

// ==== fetch_frontend.sv ====
// fetch front end top level; connects address generator, target buffer, predictor and stack
module fetch_frontend import frontend_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  resolve_t resolve,
  output fetch_t   fetch,
  output logic     fetch_valid,
  input  logic     fetch_ready
);

  addr_t    lookup_pc;
  btb_hit_t btb;
  logic     pred_taken;
  addr_t    ras_top;
  addr_t    ras_push_addr;
  logic     ras_push;
  logic     ras_pop;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .resolve       (resolve),
    .lookup_pc     (lookup_pc),
    .btb           (btb),
    .pred_taken    (pred_taken),
    .ras_top       (ras_top),
    .ras_push      (ras_push),
    .ras_pop       (ras_pop),
    .ras_push_addr (ras_push_addr),
    .fetch         (fetch),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready)
  );

  target_buffer u_btb (
    .clk       (clk),
    .rst       (rst),
    .lookup_pc (lookup_pc),
    .btb       (btb),
    .resolve   (resolve)
  );

  // indexed with the history of the block being looked up
  direction_predictor u_pred (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc   (lookup_pc),
    .lookup_hist (fetch.hist),
    .pred_taken  (pred_taken),
    .resolve     (resolve)
  );

  return_stack u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (ras_push),
    .push_addr (ras_push_addr),
    .pop       (ras_pop),
    .top       (ras_top)
  );

endmodule

// ==== fetch_input.txt ====
# T <name> starts a test after a fresh reset; E <pc> <pred_taken> <n> expects n sequential blocks
# R <transfers> <src_pc> <target> <taken> <kind> <mispredict> <hist>, hex except transfers
# kind 0 cond, 1 jump, 2 call, 3 ret
T reset_seq
E 00001000 0 24
T mispredict
R 3 00001020 00003000 1 1 1 0000
R 5 00003000 00004000 0 0 1 0001
E 00001000 0 3
E 00003000 0 2
E 00003010 0 2
T jump_learn
R 2 00001010 00005000 1 1 0 0000
R 4 00001000 00000000 0 0 1 0000
E 00001000 0 4
E 00001010 0 1
E 00005000 1 2
T call_return
R 0 00001010 00006000 1 2 0 0000
R 0 00006020 00001020 1 3 0 0000
E 00001000 0 2
E 00006000 1 3
E 00001020 1 2
T cond_predict
R 4 00001020 00002000 1 0 0 0000
R 4 00001020 00002000 1 0 0 0000
R 4 00000ff0 00000000 0 0 1 0000
E 00001000 0 4
E 00001000 0 3
E 00002000 1 2

// ==== fetch_pc_gen.sv ====
// fetch address and history registers, next-address choice and valid/ready output stage
`include "frontend_consts.svh"

module fetch_pc_gen import frontend_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  resolve_t resolve,
  output addr_t    lookup_pc,
  input  btb_hit_t btb,
  input  logic     pred_taken,
  input  addr_t    ras_top,
  output logic     ras_push,
  output logic     ras_pop,
  output addr_t    ras_push_addr,
  output fetch_t   fetch,
  output logic     fetch_valid,
  input  logic     fetch_ready
);

  fetch_t fetch_q;
  logic   valid_q;
  logic   redirect;
  logic   xfer;
  logic   hit_taken;
  addr_t  seq_pc;
  addr_t  fix_pc;
  fetch_t next_f; // predicted successor of the current block

  assign redirect = resolve.valid && resolve.mispredict;
  assign xfer = valid_q && fetch_ready;

  assign seq_pc = fetch_q.pc + addr_t'(`FETCH_BYTES);
  assign fix_pc = resolve.taken ? resolve.target : resolve.src_pc + addr_t'(`FETCH_BYTES);

  assign lookup_pc = fetch_q.pc;
  assign ras_push_addr = seq_pc; // return lands after the call block

  always_comb begin
    hit_taken = 1'b0;
    next_f.pc = seq_pc;
    ras_push = 1'b0;
    ras_pop = 1'b0;
    if (btb.hit) begin
      case (btb.kind)
        kind_jump, kind_call: begin
          hit_taken = 1'b1;
          next_f.pc = btb.target;
          ras_push = (btb.kind == kind_call);
        end
        kind_ret: begin
          hit_taken = 1'b1;
          next_f.pc = ras_top;
          ras_pop = 1'b1;
        end
        default: begin
          hit_taken = pred_taken; // cond, trust the vote
          if (pred_taken) begin
            next_f.pc = btb.target;
          end
        end
      endcase
    end
    next_f.pred_taken = hit_taken;
    next_f.hist = btb.hit ? {fetch_q.hist[`HIST_W-2:0], hit_taken} : fetch_q.hist;
    // stack moves only for blocks that actually leave on the right path
    if (!xfer || redirect) begin
      ras_push = 1'b0;
      ras_pop = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      fetch_q.pc <= `RESET_PC;
      fetch_q.pred_taken <= 1'b0;
      fetch_q.hist <= '0;
    end else begin
      valid_q <= 1'b1;
      if (redirect) begin
        fetch_q.pc <= fix_pc;
        fetch_q.pred_taken <= 1'b0;
        fetch_q.hist <= {resolve.hist[`HIST_W-2:0], resolve.taken};
      end else if (xfer) begin
        fetch_q <= next_f;
      end
    end
  end

  assign fetch = fetch_q;
  assign fetch_valid = valid_q;

  a_payload_held: assert property (
    @(posedge clk) disable iff (rst)
    valid_q && !fetch_ready && !redirect |=> valid_q && $stable(fetch_q)
  ) else $error("fetch payload changed while waiting");

  // a lone push shows up as the new stack top
  a_ras_push: assert property (
    @(posedge clk) disable iff (rst)
    ras_push |=> !$past(ras_pop) && ras_top == $past(ras_push_addr)
  ) else $error("return stack push collided with a pop or was lost");

endmodule

// ==== flist.f ====
+incdir+.
frontend_pkg.sv
target_buffer.sv
direction_predictor.sv
return_stack.sv
fetch_pc_gen.sv
fetch_frontend.sv
tb_fetch_frontend.sv

// ==== frontend_consts.svh ====
// widths, table sizes and reset address shared by the fetch front end; include where needed
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// address and fetch block
`define ADDR_W 32
`define FETCH_BYTES 16
`define BLOCK_OFS_W 4 // byte offset inside a fetch block

// branch target buffer, 64 entries
`define BTB_IDX_W 6

// direction predictor tables, 256 counters each
`define PRED_IDX_W 8

// global history lengths
`define HIST_W 14
`define HIST_A_W 2
`define HIST_B_W 8

// return stack, 8 entries
`define RAS_DEPTH_W 3

// first fetch address out of reset
`define RESET_PC 32'h0000_1000

`endif

// ==== frontend_pkg.sv ====
// types passed between the fetch front end blocks; imported by each module header
`include "frontend_consts.svh"

package frontend_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`HIST_W-1:0] hist_t; // newest outcome in bit 0

  // address bits above the buffer index and the block offset
  typedef logic [`ADDR_W-`BTB_IDX_W-`BLOCK_OFS_W-1:0] btb_tag_t;
  typedef logic [`BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [`PRED_IDX_W-1:0] pred_idx_t;
  typedef logic [`RAS_DEPTH_W-1:0] ras_ptr_t;

  typedef logic [1:0] ctr_t; // 2-bit saturating counter

  typedef enum logic [1:0] {
    kind_cond,
    kind_jump,
    kind_call,
    kind_ret
  } branch_kind_t;

  typedef struct packed {
    logic         hit;
    branch_kind_t kind;
    addr_t        target;
  } btb_hit_t;

  typedef struct packed {
    addr_t pc;
    logic  pred_taken; // block was reached by a predicted-taken branch
    hist_t hist;
  } fetch_t;

  // one resolved branch from the back end, never stalled
  typedef struct packed {
    logic         valid;
    addr_t        src_pc;
    addr_t        target;
    logic         taken;
    branch_kind_t kind;
    logic         mispredict;
    hist_t        hist; // snapshot taken at fetch
  } resolve_t;

endpackage

// ==== return_stack.sv ====
// circular return address stack, pushed on predicted calls and popped on predicted returns
`include "frontend_consts.svh"

module return_stack import frontend_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  addr_t push_addr,
  input  logic  pop,
  output addr_t top
);

  localparam int depth = 1 << `RAS_DEPTH_W;

  addr_t    stack_q [depth];
  ras_ptr_t sp_q; // points at the most recent push
  ras_ptr_t sp_inc;
  ras_ptr_t sp_dec;

  assign sp_inc = sp_q + 1'b1; // wraps, oldest entry lost on overflow
  assign sp_dec = sp_q - 1'b1;

  assign top = stack_q[sp_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      sp_q <= '0;
    end else if (push) begin
      sp_q <= sp_inc;
    end else if (pop) begin
      sp_q <= sp_dec; // underflow just wraps
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_q[sp_inc] <= push_addr;
    end
  end

endmodule

// ==== target_buffer.sv ====
// direct-mapped branch target buffer; combinational lookup, written by taken resolves
`include "frontend_consts.svh"

module target_buffer import frontend_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  addr_t    lookup_pc,
  output btb_hit_t btb,
  input  resolve_t resolve
);

  localparam int n_entries = 1 << `BTB_IDX_W;

  typedef struct packed {
    btb_tag_t     tag;
    branch_kind_t kind;
    addr_t        target;
  } btb_entry_t;

  logic       valid_q [n_entries];
  btb_entry_t entry_q [n_entries];

  btb_idx_t   rd_idx;
  btb_idx_t   wr_idx;
  btb_tag_t   rd_tag;
  btb_entry_t rd_entry;
  btb_entry_t wr_entry;
  logic       wr_en;

  assign rd_idx = lookup_pc[`BLOCK_OFS_W +: `BTB_IDX_W];
  assign rd_tag = lookup_pc[`ADDR_W-1:`BLOCK_OFS_W+`BTB_IDX_W];
  assign rd_entry = entry_q[rd_idx];

  always_comb begin
    btb.hit = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
    btb.kind = rd_entry.kind;
    btb.target = rd_entry.target;
  end

  // any taken branch is worth remembering, cond ones included
  assign wr_en = resolve.valid && resolve.taken;
  assign wr_idx = resolve.src_pc[`BLOCK_OFS_W +: `BTB_IDX_W];

  always_comb begin
    wr_entry.tag = resolve.src_pc[`ADDR_W-1:`BLOCK_OFS_W+`BTB_IDX_W];
    wr_entry.kind = resolve.kind;
    wr_entry.target = resolve.target;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < n_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entry_q[wr_idx] <= wr_entry; // replaces whatever aliased here
    end
  end

endmodule

// ==== tb_fetch_frontend.sv ====
// testbench for the fetch front end; replays fetch_input.txt, run from the project root
`include "frontend_consts.svh"

module tb_fetch_frontend import frontend_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    int       at; // transfers seen before the resolve is driven
    resolve_t r;
  } event_t;

  typedef struct packed {
    addr_t pc;
    logic  pred_taken;
  } expect_t;

  logic     clk = 1'b0;
  logic     rst;
  resolve_t resolve;
  fetch_t   fetch;
  logic     fetch_valid;
  logic     fetch_ready;

  event_t          events [$];
  expect_t         expects [$];
  logic [8*24-1:0] test_name [$];
  int              ev_first [$];
  int              exp_first [$];
  logic [31:0]     lfsr = 32'h86f3f780;
  int              test_errs;
  longint          limit_ns = 0;

  fetch_frontend DUT (
    .clk         (clk),
    .rst         (rst),
    .resolve     (resolve),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready)
  );

  always #4 clk = ~clk; // 8 ns period

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t want);
    if (got !== want) begin
      $display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, want);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("[ERROR] %0d ns %s got %b expected %b", $time, name, got, want);
      test_errs++;
    end
  endtask

  task automatic check_hist(input string name, input hist_t got, input hist_t want);
    if (got !== want) begin
      $display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, want);
      test_errs++;
    end
  endtask

  task automatic load_input(output bit ok);
    int              fd;
    int              c;
    int              n;
    logic [8*24-1:0] word;
    logic [31:0]     v_pc;
    logic [31:0]     v_tgt;
    logic [31:0]     v_taken;
    logic [31:0]     v_kind;
    logic [31:0]     v_misp;
    logic [31:0]     v_hist;
    event_t          e;
    expect_t         x;
    ok = 1'b1;
    fd = $fopen("fetch_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open fetch_input.txt");
      ok = 1'b0;
      return;
    end
    forever begin
      word = '0;
      if ($fscanf(fd, "%s", word) != 1) break;
      if (word == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);
      end else if (word == "T") begin
        word = '0;
        void'($fscanf(fd, "%s", word));
        test_name.push_back(word);
        ev_first.push_back(events.size());
        exp_first.push_back(expects.size());
      end else if (word == "R" && test_name.size() > 0) begin
        void'($fscanf(fd, "%d %h %h %h %h %h %h", n, v_pc, v_tgt, v_taken, v_kind,
                      v_misp, v_hist));
        e = '0;
        e.at = n;
        e.r.valid = 1'b1;
        e.r.src_pc = v_pc;
        e.r.target = v_tgt;
        e.r.taken = v_taken[0];
        e.r.kind = branch_kind_t'(v_kind[1:0]);
        e.r.mispredict = v_misp[0];
        e.r.hist = v_hist[`HIST_W-1:0];
        events.push_back(e);
      end else if (word == "E" && test_name.size() > 0) begin
        void'($fscanf(fd, "%h %h %d", v_pc, v_taken, n));
        for (int i = 0; i < n; i++) begin // run of sequential blocks
          x.pc = v_pc + i * `FETCH_BYTES;
          x.pred_taken = (i == 0) ? v_taken[0] : 1'b0;
          expects.push_back(x);
        end
      end else begin
        $display("unexpected record in fetch_input.txt");
        ok = 1'b0;
      end
    end
    $fclose(fd);
    ev_first.push_back(events.size()); // end markers for the last test
    exp_first.push_back(expects.size());
    if (test_name.size() == 0) ok = 1'b0;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    resolve = '0;
    fetch_ready = 1'b0;
    repeat (8) begin
      @(posedge clk);
      #1;
      check_bit("fetch_valid", fetch_valid, 1'b0);
    end
    rst = 1'b0;
  endtask

  task automatic run_test(input int t);
    int     k;
    int     ev;
    int     xfers;
    int     cycle;
    int     bi;
    fetch_t prev;
    logic   prev_wait;
    hist_t  exp_hist;
    addr_t  btb_src [1 << `BTB_IDX_W]; // last taken branch per buffer index
    bit     btb_set [1 << `BTB_IDX_W];
    k = exp_first[t];
    ev = ev_first[t];
    xfers = 0;
    cycle = 0;
    prev = '0;
    prev_wait = 1'b0;
    exp_hist = '0;
    foreach (btb_set[i]) begin
      btb_set[i] = 1'b0;
    end
    while (k < exp_first[t+1]) begin
      if (cycle == 1) begin
        check_bit("fetch_valid", fetch_valid, 1'b1); // first cycle out of reset
      end
      if (prev_wait) begin
        check_addr("fetch.pc", fetch.pc, prev.pc);
        check_bit("fetch.pred_taken", fetch.pred_taken, prev.pred_taken);
        check_hist("fetch.hist", fetch.hist, prev.hist);
      end
      if (ev < ev_first[t+1] && events[ev].at <= xfers) begin
        // ready low so a resolve never lands on a transfer edge
        resolve = events[ev].r;
        fetch_ready = 1'b0;
        prev_wait = fetch_valid && !events[ev].r.mispredict;
        if (events[ev].r.taken) begin
          bi = events[ev].r.src_pc[`BLOCK_OFS_W +: `BTB_IDX_W];
          btb_src[bi] = events[ev].r.src_pc;
          btb_set[bi] = 1'b1;
        end
        if (events[ev].r.mispredict) begin
          exp_hist = {events[ev].r.hist[`HIST_W-2:0], events[ev].r.taken};
        end
        ev++;
      end else begin
        resolve = '0;
        fetch_ready = lfsr[0];
        lfsr = lfsr_next(lfsr);
        prev_wait = fetch_valid && !fetch_ready;
        if (fetch_valid && fetch_ready) begin
          check_addr("fetch.pc", fetch.pc, expects[k].pc);
          check_bit("fetch.pred_taken", fetch.pred_taken, expects[k].pred_taken);
          check_hist("fetch.hist", fetch.hist, exp_hist);
          // a hit on this block shifts its predicted direction into history
          bi = expects[k].pc[`BLOCK_OFS_W +: `BTB_IDX_W];
          if (k + 1 < exp_first[t+1] && btb_set[bi] &&
              (btb_src[bi] >> `BLOCK_OFS_W) == (expects[k].pc >> `BLOCK_OFS_W)) begin
            exp_hist = {exp_hist[`HIST_W-2:0], expects[k+1].pred_taken};
          end
          k++;
          xfers++;
        end
      end
      prev = fetch;
      cycle++;
      @(posedge clk);
      #1;
    end
    resolve = '0;
    fetch_ready = 1'b0;
  endtask

  initial begin : main
    bit load_ok;
    int passed;
    int total_errs;
    passed = 0;
    total_errs = 0;
    rst = 1'b1;
    fetch_ready = 1'b0;
    resolve = '0;
    load_input(load_ok);
    if (!load_ok) begin
      $display("test input could not be loaded");
      $display("tests failed");
      $finish;
    end else begin
      limit_ns = (longint'(expects.size()) * 20 + longint'(test_name.size()) * 16) * 8;
      for (int t = 0; t < test_name.size(); t++) begin
        test_errs = 0;
        apply_reset();
        run_test(t);
        if (test_errs == 0) begin
          $display("test %0s: pass", test_name[t]);
          passed++;
        end else begin
          $display("test %0s: fail with %0d errors", test_name[t], test_errs);
        end
        total_errs += test_errs;
      end
      $display("%0d of %0d tests ok, %0d errors", passed, test_name.size(), total_errs);
      if (total_errs == 0 && passed == test_name.size()) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (limit_ns != 0);
    #(limit_ns);
    $display("watchdog expired, run did not finish within %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

endmodule
